// File: design/mem_stage_pkg.sv
package mem_stage_pkg;

    // data path and address width
    localparam int xlen = 64;

    // memory geometry
    localparam int num_banks  = 8;
    localparam int lane_bits  = 3;     // byte offset inside a row
    localparam int row_bits   = 8;
    localparam int bank_depth = 256;   // rows per bank
    localparam int mem_bytes  = 2048;  // window, address wraps here

    // address used when no source is selected
    localparam logic [63:0] fixed_base = 64'h0000_0000_8000_0000;

    // memory opcode, same codes as the core control word
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_ld   = 4'd1,
        op_lw   = 4'd2,
        op_lh   = 4'd3,
        op_lb   = 4'd4,
        op_lwu  = 4'd5,
        op_lhu  = 4'd6,
        op_lbu  = 4'd7,
        op_sd   = 4'd8,
        op_sw   = 4'd9,
        op_sh   = 4'd10,
        op_sb   = 4'd11
    } mem_op_e;

    // address source
    typedef enum logic [2:0] {
        addr_base = 3'd0,
        addr_dest = 3'd1,
        addr_rs1  = 3'd2,
        addr_rs2  = 3'd3,
        addr_imm  = 3'd4,
        addr_snpc = 3'd5
    } addr_sel_e;

    // store data source
    typedef enum logic [2:0] {
        data_dest = 3'd0,
        data_rs1  = 3'd1,
        data_rs2  = 3'd2,
        data_imm  = 3'd3,
        data_snpc = 3'd4
    } data_sel_e;

endpackage

// File: design/mem_req_decode.sv
`timescale 1ns/100ps

module mem_req_decode (
    input  logic [mem_stage_pkg::xlen-1:0]                               dest,
    input  logic [mem_stage_pkg::xlen-1:0]                               rs1_data,
    input  logic [mem_stage_pkg::xlen-1:0]                               rs2_data,
    input  logic [mem_stage_pkg::xlen-1:0]                               imm,
    input  logic [mem_stage_pkg::xlen-1:0]                               snpc,
    input  mem_stage_pkg::mem_op_e                                       mem_op,
    input  mem_stage_pkg::addr_sel_e                                     addr_sel,
    input  mem_stage_pkg::data_sel_e                                     data_sel,
    output logic [mem_stage_pkg::num_banks-1:0]                          lane_en,
    output logic [mem_stage_pkg::num_banks-1:0]                          lane_we,
    output logic [mem_stage_pkg::num_banks-1:0][mem_stage_pkg::row_bits-1:0] lane_row,
    output logic [mem_stage_pkg::num_banks-1:0][7:0]                     lane_wdata,
    output mem_stage_pkg::mem_op_e                                       load_op,
    output logic [mem_stage_pkg::lane_bits-1:0]                          byte_off
);

    logic [mem_stage_pkg::xlen-1:0]      addr;
    logic [mem_stage_pkg::xlen-1:0]      wdata;
    logic [mem_stage_pkg::xlen-1:0]      wdata_rot;
    logic [mem_stage_pkg::num_banks-1:0] width_mask;
    logic [mem_stage_pkg::num_banks-1:0] mask_rot;
    logic [mem_stage_pkg::row_bits-1:0]  base_row;

    always_comb begin
        case (addr_sel)
            mem_stage_pkg::addr_base: addr = mem_stage_pkg::fixed_base;
            mem_stage_pkg::addr_dest: addr = dest;
            mem_stage_pkg::addr_rs1:  addr = rs1_data;
            mem_stage_pkg::addr_rs2:  addr = rs2_data;
            mem_stage_pkg::addr_imm:  addr = imm;
            mem_stage_pkg::addr_snpc: addr = snpc;
            default:                  addr = mem_stage_pkg::fixed_base;
        endcase
    end

    always_comb begin
        case (data_sel)
            mem_stage_pkg::data_dest: wdata = dest;
            mem_stage_pkg::data_rs1:  wdata = rs1_data;
            mem_stage_pkg::data_rs2:  wdata = rs2_data;
            mem_stage_pkg::data_imm:  wdata = imm;
            mem_stage_pkg::data_snpc: wdata = snpc;
            default:                  wdata = '0;
        endcase
    end

    assign byte_off = addr[mem_stage_pkg::lane_bits-1:0];
    assign base_row = addr[mem_stage_pkg::lane_bits +: mem_stage_pkg::row_bits]; // upper bits dropped

    // store width in bytes, as a lane mask before rotation
    always_comb begin
        case (mem_op)
            mem_stage_pkg::op_sd: width_mask = 8'hff;
            mem_stage_pkg::op_sw: width_mask = 8'h0f;
            mem_stage_pkg::op_sh: width_mask = 8'h03;
            mem_stage_pkg::op_sb: width_mask = 8'h01;
            default:              width_mask = 8'h00;
        endcase
    end

    // rotate left by byte_off lanes
    assign mask_rot  = (width_mask << byte_off)
                     | (width_mask >> (mem_stage_pkg::num_banks - byte_off));
    assign wdata_rot = (wdata << (8 * byte_off))
                     | (wdata >> (mem_stage_pkg::xlen - 8 * byte_off));

    always_comb begin
        lane_en = '0;
        lane_we = '0;
        load_op = mem_stage_pkg::op_none;
        case (mem_op)
            mem_stage_pkg::op_ld, mem_stage_pkg::op_lw, mem_stage_pkg::op_lh,
            mem_stage_pkg::op_lb, mem_stage_pkg::op_lwu, mem_stage_pkg::op_lhu,
            mem_stage_pkg::op_lbu: begin
                lane_en = '1; // read every lane
                load_op = mem_op;
            end
            mem_stage_pkg::op_sd, mem_stage_pkg::op_sw,
            mem_stage_pkg::op_sh, mem_stage_pkg::op_sb: begin
                lane_en = mask_rot;
                lane_we = mask_rot;
            end
            default: begin
                lane_en = '0;
            end
        endcase
    end

    always_comb begin
        for (int b = 0; b < mem_stage_pkg::num_banks; b++) begin
            lane_wdata[b] = wdata_rot[8*b +: 8];
            if (b < int'(byte_off)) begin
                lane_row[b] = base_row + 1'b1; // wrapped into next row
            end else begin
                lane_row[b] = base_row;
            end
        end
    end

endmodule

// File: design/mem_byte_bank.sv
`timescale 1ns/100ps

module mem_byte_bank (
    input  logic                               clk,
    input  logic                               en,
    input  logic                               we,
    input  logic [mem_stage_pkg::row_bits-1:0] row,
    input  logic [7:0]                         wdata,
    output logic [7:0]                         rdata
);

    logic [7:0] mem [mem_stage_pkg::bank_depth];

    // write first, read registered, rdata holds when idle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[row] <= wdata;
            end else begin
                rdata <= mem[row];
            end
        end
    end

endmodule

// File: design/load_align.sv
`timescale 1ns/100ps

module load_align (
    input  logic                                      clk,
    input  logic                                      rst,
    input  mem_stage_pkg::mem_op_e                    load_op,
    input  logic [mem_stage_pkg::lane_bits-1:0]       byte_off,
    input  logic [mem_stage_pkg::num_banks-1:0][7:0]  bank_rdata,
    output logic [mem_stage_pkg::xlen-1:0]            read_data
);

    mem_stage_pkg::mem_op_e                op_q;
    logic [mem_stage_pkg::lane_bits-1:0]   off_q;
    logic [mem_stage_pkg::xlen-1:0]        raw;
    logic [mem_stage_pkg::xlen-1:0]        rot;

    // pending load, lines up with the bank read edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            op_q  <= mem_stage_pkg::op_none;
            off_q <= '0;
        end else begin
            op_q  <= load_op;
            off_q <= byte_off;
        end
    end

    assign raw = bank_rdata; // lane b in byte b

    // rotate right so byte k of the access lands in byte k
    assign rot = (raw >> (8 * off_q))
               | (raw << (mem_stage_pkg::xlen - 8 * off_q));

    always_comb begin
        case (op_q)
            mem_stage_pkg::op_ld: begin
                read_data = rot;
            end
            mem_stage_pkg::op_lw: begin
                read_data = {{32{rot[31]}}, rot[31:0]};
            end
            mem_stage_pkg::op_lh: begin
                read_data = {{48{rot[15]}}, rot[15:0]};
            end
            mem_stage_pkg::op_lb: begin
                read_data = {{56{rot[7]}}, rot[7:0]}; // signed byte
            end
            mem_stage_pkg::op_lwu: begin
                read_data = {32'd0, rot[31:0]};
            end
            mem_stage_pkg::op_lhu: begin
                read_data = {48'd0, rot[15:0]};
            end
            mem_stage_pkg::op_lbu: begin
                read_data = {56'd0, rot[7:0]};
            end
            default: begin
                read_data = '0; // no load pending
            end
        endcase
    end

endmodule

// File: design/mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mem_stage_pkg::xlen-1:0]  dest,
    input  logic [mem_stage_pkg::xlen-1:0]  rs1_data,
    input  logic [mem_stage_pkg::xlen-1:0]  rs2_data,
    input  logic [mem_stage_pkg::xlen-1:0]  imm,
    input  logic [mem_stage_pkg::xlen-1:0]  snpc,
    input  mem_stage_pkg::mem_op_e          mem_op,
    input  mem_stage_pkg::addr_sel_e        addr_sel,
    input  mem_stage_pkg::data_sel_e        data_sel,
    output logic [mem_stage_pkg::xlen-1:0]  read_data
);

    logic [mem_stage_pkg::num_banks-1:0]                              lane_en;
    logic [mem_stage_pkg::num_banks-1:0]                              lane_we;
    logic [mem_stage_pkg::num_banks-1:0][mem_stage_pkg::row_bits-1:0] lane_row;
    logic [mem_stage_pkg::num_banks-1:0][7:0]                         lane_wdata;
    logic [mem_stage_pkg::num_banks-1:0][7:0]                         bank_rdata;
    mem_stage_pkg::mem_op_e                                           load_op;
    logic [mem_stage_pkg::lane_bits-1:0]                              byte_off;

    mem_req_decode u_decode (
        .dest       (dest),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .snpc       (snpc),
        .mem_op     (mem_op),
        .addr_sel   (addr_sel),
        .data_sel   (data_sel),
        .lane_en    (lane_en),
        .lane_we    (lane_we),
        .lane_row   (lane_row),
        .lane_wdata (lane_wdata),
        .load_op    (load_op),
        .byte_off   (byte_off)
    );

    // bank b holds bytes with address mod 8 == b
    for (genvar b = 0; b < mem_stage_pkg::num_banks; b++) begin : g_bank
        mem_byte_bank u_bank (
            .clk   (clk),
            .en    (lane_en[b]),
            .we    (lane_we[b]),
            .row   (lane_row[b]),
            .wdata (lane_wdata[b]),
            .rdata (bank_rdata[b])
        );
    end

    load_align u_align (
        .clk        (clk),
        .rst        (rst),
        .load_op    (load_op),
        .byte_off   (byte_off),
        .bank_rdata (bank_rdata),
        .read_data  (read_data)
    );

endmodule

// File: testbench/mem_stage_chk.sv
`timescale 1ns/100ps

module mem_stage_chk (
    input logic                           clk,
    input logic                           rst,
    input logic [mem_stage_pkg::xlen-1:0] dest,
    input logic [mem_stage_pkg::xlen-1:0] rs1_data,
    input logic [mem_stage_pkg::xlen-1:0] rs2_data,
    input logic [mem_stage_pkg::xlen-1:0] imm,
    input logic [mem_stage_pkg::xlen-1:0] snpc,
    input logic [3:0]                     mem_op,
    input logic [2:0]                     addr_sel,
    input logic [2:0]                     data_sel,
    input logic [mem_stage_pkg::xlen-1:0] read_data
);

    logic [7:0]                     shadow [mem_stage_pkg::mem_bytes];
    logic [mem_stage_pkg::xlen-1:0] eff_addr;
    logic [mem_stage_pkg::xlen-1:0] st_data;
    logic [mem_stage_pkg::xlen-1:0] exp_q;
    int                             fail_count = 0;

    // window index of byte k of an access at a
    function automatic int win(input logic [63:0] a, input int k);
        return int'((a + 64'(k)) % 64'(mem_stage_pkg::mem_bytes));
    endfunction

    function automatic bit is_load(input logic [3:0] op);
        return op >= mem_stage_pkg::op_ld && op <= mem_stage_pkg::op_lbu;
    endfunction

    function automatic bit is_store(input logic [3:0] op);
        return op >= mem_stage_pkg::op_sd && op <= mem_stage_pkg::op_sb;
    endfunction

    function automatic int op_bytes(input logic [3:0] op);
        case (op)
            mem_stage_pkg::op_ld, mem_stage_pkg::op_sd: return 8;
            mem_stage_pkg::op_lw, mem_stage_pkg::op_lwu, mem_stage_pkg::op_sw: return 4;
            mem_stage_pkg::op_lh, mem_stage_pkg::op_lhu, mem_stage_pkg::op_sh: return 2;
            mem_stage_pkg::op_lb, mem_stage_pkg::op_lbu, mem_stage_pkg::op_sb: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic logic [63:0] expect_load(input logic [3:0] op, input logic [63:0] a);
        logic [63:0] v;
        int          n;
        v = '0;
        n = is_load(op) ? op_bytes(op) : 0;
        for (int k = 0; k < n; k++) begin
            v[8*k +: 8] = shadow[win(a, k)];
        end
        if (op inside {mem_stage_pkg::op_lw, mem_stage_pkg::op_lh, mem_stage_pkg::op_lb}
            && v[8*n-1]) begin
            v = v | ~((64'd1 << (8 * n)) - 64'd1); // sign fill
        end
        return v;
    endfunction

    always_comb begin
        case (addr_sel)
            mem_stage_pkg::addr_dest: eff_addr = dest;
            mem_stage_pkg::addr_rs1:  eff_addr = rs1_data;
            mem_stage_pkg::addr_rs2:  eff_addr = rs2_data;
            mem_stage_pkg::addr_imm:  eff_addr = imm;
            mem_stage_pkg::addr_snpc: eff_addr = snpc;
            default:                  eff_addr = mem_stage_pkg::fixed_base;
        endcase
        case (data_sel)
            mem_stage_pkg::data_dest: st_data = dest;
            mem_stage_pkg::data_rs1:  st_data = rs1_data;
            mem_stage_pkg::data_rs2:  st_data = rs2_data;
            mem_stage_pkg::data_imm:  st_data = imm;
            mem_stage_pkg::data_snpc: st_data = snpc;
            default:                  st_data = '0;
        endcase
    end

    // expected value uses the shadow before this cycle's store
    always_ff @(posedge clk) begin
        if (!rst) begin
            exp_q <= '0;
        end else begin
            exp_q <= expect_load(mem_op, eff_addr);
        end
        if (is_store(mem_op)) begin
            for (int k = 0; k < op_bytes(mem_op); k++) begin
                shadow[win(eff_addr, k)] <= st_data[8*k +: 8];
            end
        end
    end

    read_data_match: assert property (@(posedge clk) disable iff (!rst) read_data == exp_q)
    else begin
        fail_count++;
        $error("ERROR read_data %h expected %h", $sampled(read_data), $sampled(exp_q));
    end

    reset_zero: assert property (@(posedge clk) !$past(rst) |-> read_data == '0)
    else begin
        fail_count++;
        $error("ERROR read_data %h expected 0 after reset", $sampled(read_data));
    end

    idle_zero: assert property (@(posedge clk) disable iff (!rst)
        !is_load($past(mem_op)) |-> read_data == '0)
    else begin
        fail_count++;
        $error("ERROR read_data %h expected 0 after non-load", $sampled(read_data));
    end

endmodule

bind mem_stage mem_stage_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .dest      (dest),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .snpc      (snpc),
    .mem_op    (mem_op),
    .addr_sel  (addr_sel),
    .data_sel  (data_sel),
    .read_data (read_data)
);

// File: testbench/tb_mem_stage.sv
`timescale 1ns/100ps

module tb_mem_stage;

    localparam int prefill_ops  = mem_stage_pkg::mem_bytes / 8;
    localparam int directed_ops = 100;  // bound on directed ops and idles
    localparam int select_ops   = 128;
    localparam int random_ops   = 200;
    localparam int total_ops    = prefill_ops + directed_ops + select_ops + random_ops;
    localparam int watchdog_ns  = (total_ops + 50) * 4;

    logic                     clk;
    logic                     rst;
    logic [63:0]              dest;
    logic [63:0]              rs1_data;
    logic [63:0]              rs2_data;
    logic [63:0]              imm;
    logic [63:0]              snpc;
    mem_stage_pkg::mem_op_e   mem_op;
    mem_stage_pkg::addr_sel_e addr_sel;
    mem_stage_pkg::data_sel_e data_sel;
    logic [63:0]              read_data;
    int                       timeouts = 0;

    mem_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // byte value from all 11 window address bits
    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ (8'(a[10:8]) * 8'h4b);
    endfunction

    task automatic access(input mem_stage_pkg::mem_op_e op, input logic [2:0] a_sel,
                          input logic [2:0] d_sel, input logic [63:0] addr,
                          input logic [63:0] data);
        logic [63:0] opnd [5];
        @(negedge clk);
        for (int i = 0; i < 5; i++) begin
            opnd[i] = {$urandom, $urandom};  // unused sources get noise
        end
        if (d_sel < 3'd5) opnd[d_sel] = data;
        if (a_sel >= 3'd1 && a_sel <= 3'd5) opnd[a_sel - 3'd1] = addr;
        {dest, rs1_data, rs2_data, imm, snpc} = {opnd[0], opnd[1], opnd[2], opnd[3], opnd[4]};
        mem_op   = op;
        addr_sel = mem_stage_pkg::addr_sel_e'(a_sel);
        data_sel = mem_stage_pkg::data_sel_e'(d_sel);
    endtask

    task automatic store(input mem_stage_pkg::mem_op_e op, input logic [63:0] addr,
                         input logic [63:0] data);
        access(op, mem_stage_pkg::addr_rs1, mem_stage_pkg::data_rs2, addr, data);
    endtask

    task automatic load(input mem_stage_pkg::mem_op_e op, input logic [63:0] addr);
        access(op, mem_stage_pkg::addr_rs1, mem_stage_pkg::data_rs2, addr, 64'd0);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            access(mem_stage_pkg::op_none, mem_stage_pkg::addr_rs1, mem_stage_pkg::data_rs2,
                   64'd0, 64'd0);
        end
    endtask

    task automatic directed();
        logic [63:0] word;
        for (int r = 0; r < prefill_ops; r++) begin
            for (int k = 0; k < 8; k++) word[8*k +: 8] = fill_byte(11'(8 * r + k));
            store(mem_stage_pkg::op_sd, 64'(8 * r), word);
        end
        word = {$urandom, $urandom};
        store(mem_stage_pkg::op_sd, 64'h100, word);  // aligned round trip
        load(mem_stage_pkg::op_ld, 64'h100);
        idle(1);
        for (int off = 1; off < 8; off++) begin      // crosses into next row
            store(mem_stage_pkg::op_sd, 64'(12'h400 + 16 * off + off), {$urandom, $urandom});
            load(mem_stage_pkg::op_ld, 64'(12'h400 + 16 * off + off));
            load(mem_stage_pkg::op_lw, 64'(12'h400 + 16 * off + off));
        end
        store(mem_stage_pkg::op_sd, 64'h7fd, ~word);  // wraps at window edge
        load(mem_stage_pkg::op_ld, 64'h7fd);
        store(mem_stage_pkg::op_sd, 64'hffff_ffff_ffff_fffb, word);
        load(mem_stage_pkg::op_ld, 64'h7fb);
        store(mem_stage_pkg::op_sd, 64'h200, 64'h8899_aabb_ccdd_eeff);
        store(mem_stage_pkg::op_sd, 64'h208, 64'h0011_2233_4455_6677);
        for (int i = 1; i <= 7; i++) begin
            load(mem_stage_pkg::mem_op_e'(i), 64'h200);
            load(mem_stage_pkg::mem_op_e'(i), 64'h208);
            load(mem_stage_pkg::mem_op_e'(i), 64'h203);
        end
        store(mem_stage_pkg::op_sd, 64'h300, 64'h0123_4567_89ab_cdef);
        store(mem_stage_pkg::op_sw, 64'h302, 64'hdead_beef_dead_beef);
        load(mem_stage_pkg::op_ld, 64'h300);
        store(mem_stage_pkg::op_sh, 64'h305, 64'h1357_9bdf_2468_ace0);
        load(mem_stage_pkg::op_ld, 64'h300);
        store(mem_stage_pkg::op_sb, 64'h307, 64'hffff_ffff_ffff_ff5a);
        load(mem_stage_pkg::op_ld, 64'h300);
        load(mem_stage_pkg::op_ld, 64'h308);
        idle(2);
    endtask

    // every address and data select code including out-of-range ones
    task automatic source_select();
        logic [63:0] addr;
        for (int a = 0; a < 8; a++) begin
            for (int d = 0; d < 8; d++) begin
                addr = 64'(12'h600 + 16 * a + d);
                access(mem_stage_pkg::op_sd, 3'(a), 3'(d), addr, {$urandom, $urandom});
                access(mem_stage_pkg::op_ld, 3'(a), 3'($urandom), addr, 64'd0);
            end
        end
    endtask

    task automatic random_mix();
        mem_stage_pkg::mem_op_e op;
        logic [63:0]            addr;
        logic [2:0]             a_sel;
        bit                     last_store;
        last_store = 1'b0;
        for (int i = 0; i < random_ops; i++) begin
            if (last_store && $urandom % 4 == 0) begin
                op = mem_stage_pkg::mem_op_e'(4'(1 + $urandom % 7));  // same bytes back
                last_store = 1'b0;
            end else begin
                op         = mem_stage_pkg::mem_op_e'(4'($urandom % 12));
                addr       = {$urandom, $urandom};
                a_sel      = ($urandom % 8 == 0) ? 3'($urandom) : 3'(mem_stage_pkg::addr_rs1);
                last_store = op >= mem_stage_pkg::op_sd;
            end
            access(op, a_sel, 3'($urandom), addr, {$urandom, $urandom});
        end
    endtask

    task automatic finish_run();
        int asserts;
        asserts = u_dut.u_chk.fail_count;
        $display("errors: %0d (assertion failures %0d, timeouts %0d)",
                 asserts + timeouts, asserts, timeouts);
        if (asserts + timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(20081));
        rst      = 1'b0;
        dest     = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        snpc     = '0;
        mem_op   = mem_stage_pkg::op_none;
        addr_sel = mem_stage_pkg::addr_rs1;
        data_sel = mem_stage_pkg::data_rs2;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        idle(2);
        directed();
        source_select();
        random_mix();
        idle(3);
        finish_run();
    end

    initial begin
        #watchdog_ns;
        $display("timeout: stimulus did not finish within %0d ns", watchdog_ns);
        timeouts++;
        finish_run();
    end

endmodule

// File: build.f
design/mem_stage_pkg.sv
design/mem_req_decode.sv
design/mem_byte_bank.sv
design/load_align.sv
design/mem_stage.sv
testbench/mem_stage_chk.sv
testbench/tb_mem_stage.sv

// File: Makefile
SIM      := verilator
TOP      := tb_mem_stage
FILELIST := build.f
FLAGS    := --binary --timing --assert -Wno-fatal
RUNFLAGS := +verilator+error+limit+1000
LOG      := sim.log
PASS     := Result: PASSED
SRCS     := $(shell grep -v '^+' $(FILELIST))
EXE      := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(EXE): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(EXE)
	./$(EXE) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(SIM) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
